//--- mp3_defines.svh
`ifndef MP3_DEFINES_SVH
`define MP3_DEFINES_SVH

// first fetch address out of reset
`define MP3_RESET_PC 16'h0000

`define MP3_NUM_REGS 8

`endif

//--- lc3b_types.sv
`default_nettype none

package lc3b_types;

	typedef logic [15:0] lc3b_word;
	typedef logic [2:0] lc3b_reg;
	typedef logic [2:0] lc3b_nzp;

	// opcode field, ir[15:12]
	typedef enum logic [3:0] {
		op_br = 4'b0000,
		op_add = 4'b0001,
		op_and = 4'b0101,
		op_not = 4'b1001,
		op_ldr = 4'b0110,
		op_str = 4'b0111
	} lc3b_opcode;

	typedef enum logic [1:0] {alu_add, alu_and, alu_not, alu_pass} lc3b_aluop;

	typedef struct packed {
		lc3b_opcode opcode;
		lc3b_aluop aluop;
		logic sr2_is_imm;
		logic load_regfile;
		logic load_cc;
		logic mem_read;
		logic mem_write;
	} lc3b_control_word;

	typedef struct packed {
		logic valid;
		lc3b_word npc;
		lc3b_word ir;
	} lc3b_f_de;

	typedef struct packed {
		logic valid;
		lc3b_word npc;
		lc3b_word ir;
		lc3b_control_word cw;
		lc3b_word sr1;
		lc3b_word sr2;
		lc3b_nzp cc;
		lc3b_reg dr;
	} lc3b_de_ex;

	// result is store data for STR, ALU value otherwise
	typedef struct packed {
		logic valid;
		lc3b_control_word cw;
		lc3b_word address;
		lc3b_word result;
		lc3b_reg dr;
	} lc3b_ex_mem;

	typedef struct packed {
		logic valid;
		logic load_regfile;
		logic load_cc;
		lc3b_reg dr;
		lc3b_word data;
	} lc3b_mem_wb;

	typedef enum logic [1:0] {arb_idle, arb_inst, arb_data} lc3b_arb_state;

endpackage

`default_nettype wire

//--- mem_port_if.sv
`timescale 1ns/1ps
`default_nettype none

interface mem_port_if;
	import lc3b_types::*;

	lc3b_word address;
	logic read;
	logic write;
	lc3b_word wdata;
	lc3b_word rdata;
	logic resp;

	// request held until the one-cycle resp
	modport requester (
		output address, read, write, wdata,
		input rdata, resp
	);

	modport server (
		input address, read, write, wdata,
		output rdata, resp
	);
endinterface

`default_nettype wire

//--- arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module arbiter (
	input logic clk,
	input logic reset,
	mem_port_if.server inst,
	mem_port_if.server data,
	input logic pmem_resp,
	input lc3b_types::lc3b_word pmem_rdata,
	output logic pmem_read,
	output logic pmem_write,
	output lc3b_types::lc3b_word pmem_address,
	output lc3b_types::lc3b_word pmem_wdata
);
	import lc3b_types::*;

	lc3b_arb_state state;
	lc3b_arb_state grant;

	// data side wins when both ask in idle
	always_comb begin
		grant = state;
		if (state == arb_idle) begin
			if (data.read || data.write) begin
				grant = arb_data;
			end else if (inst.read || inst.write) begin
				grant = arb_inst;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= arb_idle;
		end else if (pmem_resp) begin
			state <= arb_idle;
		end else begin
			state <= grant;
		end
	end

	always_comb begin
		pmem_read = 1'b0;
		pmem_write = 1'b0;
		pmem_address = data.address;
		pmem_wdata = data.wdata;
		case (grant)
			arb_data: begin
				pmem_read = data.read;
				pmem_write = data.write;
			end
			arb_inst: begin
				pmem_read = inst.read;
				pmem_write = inst.write;
				pmem_address = inst.address;
				pmem_wdata = inst.wdata;
			end
			default: ;
		endcase
	end

	assign inst.rdata = pmem_rdata;
	assign data.rdata = pmem_rdata;
	// resp only to the owner
	assign inst.resp = pmem_resp && (grant == arb_inst);
	assign data.resp = pmem_resp && (grant == arb_data);

endmodule

`default_nettype wire

//--- fetch.sv
`timescale 1ns/1ps
`default_nettype none
`include "mp3_defines.svh"

module fetch (
	input logic clk,
	input logic reset,
	mem_port_if.requester imem,
	input logic dep_stall,
	input logic mem_stall,
	input logic redirect,
	input lc3b_types::lc3b_word target_pc,
	output lc3b_types::lc3b_f_de f_de
);
	import lc3b_types::*;

	lc3b_word pc;
	lc3b_word pending_pc;
	lc3b_word buf_ir;
	logic buf_valid;
	logic discard;
	logic hold;
	logic deliver;

	assign hold = dep_stall | mem_stall;
	assign deliver = imem.resp & ~discard & ~redirect;

	// no new fetch while the buffer is full
	assign imem.address = pc;
	assign imem.read = ~reset & ~buf_valid;
	assign imem.write = 1'b0;
	assign imem.wdata = '0;

	always_ff @(posedge clk) begin
		if (reset) begin
			pc <= `MP3_RESET_PC;
			discard <= 1'b0;
		end else begin
			if (redirect && imem.read && !imem.resp) begin
				// let the read finish before the jump
				pending_pc <= target_pc;
				discard <= 1'b1;
			end else if (redirect) begin
				pc <= target_pc;
				discard <= 1'b0;
			end else if (imem.resp) begin
				pc <= discard ? pending_pc : pc + 16'd2;
				discard <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (reset || redirect) begin
			f_de.valid <= 1'b0;
			buf_valid <= 1'b0;
		end else if (hold) begin
			if (deliver) begin
				buf_valid <= 1'b1;
				buf_ir <= imem.rdata;
			end
		end else if (buf_valid) begin
			// pc already points past the buffered word
			f_de.valid <= 1'b1;
			f_de.npc <= pc;
			f_de.ir <= buf_ir;
			buf_valid <= 1'b0;
		end else begin
			f_de.valid <= deliver;
			f_de.npc <= pc + 16'd2;
			f_de.ir <= imem.rdata;
		end
	end

endmodule

`default_nettype wire

//--- decode.sv
`timescale 1ns/1ps
`default_nettype none
`include "mp3_defines.svh"

module decode (
	input logic clk,
	input logic reset,
	input lc3b_types::lc3b_f_de f_de,
	input lc3b_types::lc3b_mem_wb mem_wb,
	input logic ex_ld_reg,
	input logic ex_ld_cc,
	input logic mem_ld_reg,
	input logic mem_ld_cc,
	input lc3b_types::lc3b_reg ex_drid,
	input lc3b_types::lc3b_reg mem_drid,
	input logic redirect,
	input logic mem_stall,
	output logic dep_stall,
	output lc3b_types::lc3b_de_ex de_ex
);
	import lc3b_types::*;

	lc3b_word regs [`MP3_NUM_REGS];
	lc3b_nzp cc;
	lc3b_nzp gen_cc;
	lc3b_opcode op;
	lc3b_control_word cw;
	lc3b_reg sr1_id;
	lc3b_reg sr2_id;
	logic use_sr1;
	logic use_sr2;
	logic cc_busy;

	// an older instruction still owes a write to r
	function automatic logic reg_busy(input lc3b_reg r);
		reg_busy = (ex_ld_reg && ex_drid == r) || (mem_ld_reg && mem_drid == r) ||
			(mem_wb.valid && mem_wb.load_regfile && mem_wb.dr == r);
	endfunction

	assign op = lc3b_opcode'(f_de.ir[15:12]);
	assign sr1_id = f_de.ir[8:6];
	// STR reads its data register through the sr2 port
	assign sr2_id = (op == op_str) ? f_de.ir[11:9] : f_de.ir[2:0];

	always_comb begin
		cw = '0;
		cw.opcode = op;
		cw.aluop = alu_pass;
		case (op)
			op_add, op_and: begin
				cw.aluop = (op == op_add) ? alu_add : alu_and;
				cw.sr2_is_imm = f_de.ir[5];
				cw.load_regfile = 1'b1;
				cw.load_cc = 1'b1;
			end
			op_not: begin
				cw.aluop = alu_not;
				cw.load_regfile = 1'b1;
				cw.load_cc = 1'b1;
			end
			op_ldr: begin
				cw.load_regfile = 1'b1;
				cw.load_cc = 1'b1;
				cw.mem_read = 1'b1;
			end
			op_str: begin
				cw.mem_write = 1'b1;
			end
			default: ;
		endcase
	end

	// everything but BR reads sr1
	assign use_sr1 = cw.load_regfile | cw.mem_write;
	assign use_sr2 = cw.mem_write | ((cw.aluop inside {alu_add, alu_and}) & ~cw.sr2_is_imm);
	assign cc_busy = ex_ld_cc | mem_ld_cc | (mem_wb.valid & mem_wb.load_cc);

	always_comb begin
		dep_stall = 1'b0;
		if (f_de.valid) begin
			dep_stall = (use_sr1 && reg_busy(sr1_id)) || (use_sr2 && reg_busy(sr2_id)) ||
				(op == op_br && cc_busy);
		end
	end

	// write-back
	assign gen_cc = mem_wb.data[15] ? 3'b100 : ((mem_wb.data == '0) ? 3'b010 : 3'b001);

	always_ff @(posedge clk) begin
		if (mem_wb.valid && mem_wb.load_regfile) begin
			regs[mem_wb.dr] <= mem_wb.data;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			cc <= 3'b010;
		end else if (mem_wb.valid && mem_wb.load_cc) begin
			cc <= gen_cc;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			de_ex.valid <= 1'b0;
		end else if (!mem_stall) begin
			// bubble on hazard or squash
			de_ex.valid <= f_de.valid & ~dep_stall & ~redirect;
			de_ex.npc <= f_de.npc;
			de_ex.ir <= f_de.ir;
			de_ex.cw <= cw;
			de_ex.sr1 <= regs[sr1_id];
			de_ex.sr2 <= regs[sr2_id];
			de_ex.cc <= cc;
			de_ex.dr <= f_de.ir[11:9];
		end
	end

endmodule

`default_nettype wire

//--- execute.sv
`timescale 1ns/1ps
`default_nettype none

module execute (
	input logic clk,
	input logic reset,
	input lc3b_types::lc3b_de_ex de_ex,
	input logic mem_stall,
	output logic redirect,
	output lc3b_types::lc3b_word target_pc,
	output logic ex_ld_reg,
	output logic ex_ld_cc,
	output lc3b_types::lc3b_reg ex_drid,
	output lc3b_types::lc3b_ex_mem ex_mem
);
	import lc3b_types::*;

	lc3b_word operand_b;
	lc3b_word alu_out;
	lc3b_word address;
	logic taken;

	assign operand_b = de_ex.cw.sr2_is_imm ? {{11{de_ex.ir[4]}}, de_ex.ir[4:0]} : de_ex.sr2;

	always_comb begin
		case (de_ex.cw.aluop)
			alu_add: alu_out = de_ex.sr1 + operand_b;
			alu_and: alu_out = de_ex.sr1 & operand_b;
			alu_not: alu_out = ~de_ex.sr1;
			// pass carries the store data
			default: alu_out = de_ex.sr2;
		endcase
	end

	// offsets count words
	assign address = de_ex.sr1 + {{9{de_ex.ir[5]}}, de_ex.ir[5:0], 1'b0};
	assign target_pc = de_ex.npc + {{6{de_ex.ir[8]}}, de_ex.ir[8:0], 1'b0};

	assign taken = de_ex.valid && (de_ex.cw.opcode == op_br) && ((de_ex.ir[11:9] & de_ex.cc) != '0);
	// only on the edge the branch leaves execute
	assign redirect = taken & ~mem_stall;

	assign ex_ld_reg = de_ex.valid & de_ex.cw.load_regfile;
	assign ex_ld_cc = de_ex.valid & de_ex.cw.load_cc;
	assign ex_drid = de_ex.dr;

	always_ff @(posedge clk) begin
		if (reset) begin
			ex_mem.valid <= 1'b0;
		end else if (!mem_stall) begin
			ex_mem.valid <= de_ex.valid;
			ex_mem.cw <= de_ex.cw;
			ex_mem.address <= address;
			ex_mem.result <= alu_out;
			ex_mem.dr <= de_ex.dr;
		end
	end

endmodule

`default_nettype wire

//--- mem.sv
`timescale 1ns/1ps
`default_nettype none

module mem (
	input logic clk,
	input logic reset,
	input lc3b_types::lc3b_ex_mem ex_mem,
	mem_port_if.requester dmem,
	output logic mem_stall,
	output logic mem_ld_reg,
	output logic mem_ld_cc,
	output lc3b_types::lc3b_reg mem_drid,
	output lc3b_types::lc3b_mem_wb mem_wb
);
	import lc3b_types::*;

	lc3b_word wb_data;

	assign dmem.address = ex_mem.address;
	assign dmem.read = ex_mem.valid & ex_mem.cw.mem_read;
	assign dmem.write = ex_mem.valid & ex_mem.cw.mem_write;
	assign dmem.wdata = ex_mem.result;

	// whole pipe waits for the data port
	assign mem_stall = (dmem.read | dmem.write) & ~dmem.resp;

	assign mem_ld_reg = ex_mem.valid & ex_mem.cw.load_regfile;
	assign mem_ld_cc = ex_mem.valid & ex_mem.cw.load_cc;
	assign mem_drid = ex_mem.dr;

	assign wb_data = ex_mem.cw.mem_read ? dmem.rdata : ex_mem.result;

	always_ff @(posedge clk) begin
		if (reset) begin
			mem_wb.valid <= 1'b0;
		end else if (!mem_stall) begin
			mem_wb.valid <= ex_mem.valid;
			mem_wb.load_regfile <= ex_mem.cw.load_regfile;
			mem_wb.load_cc <= ex_mem.cw.load_cc;
			mem_wb.dr <= ex_mem.dr;
			mem_wb.data <= wb_data;
		end
	end

endmodule

`default_nettype wire

//--- mp3.sv
`timescale 1ns/1ps
`default_nettype none

module mp3 (
	input logic clk,
	input logic reset,
	input logic pmem_resp,
	input lc3b_types::lc3b_word pmem_rdata,
	output logic pmem_read,
	output logic pmem_write,
	output lc3b_types::lc3b_word pmem_address,
	output lc3b_types::lc3b_word pmem_wdata
);
	import lc3b_types::*;

	// stage latches
	lc3b_f_de f_de;
	lc3b_de_ex de_ex;
	lc3b_ex_mem ex_mem;
	lc3b_mem_wb mem_wb;

	logic dep_stall;
	logic mem_stall;
	logic redirect;
	lc3b_word target_pc;

	// in-flight writers for the hazard check
	logic ex_ld_reg;
	logic ex_ld_cc;
	lc3b_reg ex_drid;
	logic mem_ld_reg;
	logic mem_ld_cc;
	lc3b_reg mem_drid;

	mem_port_if inst_port ();
	mem_port_if data_port ();

	fetch u_fetch (
		.imem(inst_port),
		.*
	);

	decode u_decode (.*);

	execute u_execute (.*);

	mem u_mem (
		.dmem(data_port),
		.*
	);

	arbiter u_arbiter (
		.inst(inst_port),
		.data(data_port),
		.*
	);

endmodule

`default_nettype wire

//--- mp3_props.sv
`timescale 1ns/1ps
`default_nettype none

module mp3_props (
	input logic clk,
	input logic reset,
	input logic pmem_read,
	input logic pmem_write,
	input logic pmem_resp,
	input lc3b_types::lc3b_word pmem_address
);

	read_write_exclusive: assert property (@(posedge clk) !(pmem_read && pmem_write))
		else $error("pmem_read and pmem_write high together");

	// a waiting request keeps its address until resp
	address_stable: assert property (@(posedge clk) disable iff (reset)
		((pmem_read || pmem_write) && !pmem_resp) |=>
		((pmem_read || pmem_write) && $stable(pmem_address)))
		else $error("memory request dropped or moved before resp");

	// first reset cycle may still show the old request
	quiet_in_reset: assert property (@(posedge clk)
		(reset && $past(reset)) |-> !(pmem_read || pmem_write))
		else $error("memory request raised during reset");

endmodule

bind mp3 mp3_props u_props (
	.clk(clk),
	.reset(reset),
	.pmem_read(pmem_read),
	.pmem_write(pmem_write),
	.pmem_resp(pmem_resp),
	.pmem_address(pmem_address)
);

`default_nettype wire

//--- mp3_tb.sv
`timescale 1ns/1ps
`default_nettype none
`include "mp3_defines.svh"

module mp3_tb;
	import lc3b_types::*;

	localparam int CLK_PERIOD = 8;
	localparam int NUM_PROGRAMS = 5;

	logic clk;
	logic reset;
	logic pmem_resp;
	lc3b_word pmem_rdata;
	logic pmem_read;
	logic pmem_write;
	lc3b_word pmem_address;
	lc3b_word pmem_wdata;

	// program image, copied into the memory model for each run
	lc3b_word image [256];
	lc3b_word mem [256];
	int emit_ptr;
	integer seed = 32'h65f6;

	lc3b_word exp_addr [$];
	lc3b_word exp_data [$];
	lc3b_word halt_pc;
	int store_idx;
	int halt_hits;

	mp3 u_dut (
		.clk(clk),
		.reset(reset),
		.pmem_resp(pmem_resp),
		.pmem_rdata(pmem_rdata),
		.pmem_read(pmem_read),
		.pmem_write(pmem_write),
		.pmem_address(pmem_address),
		.pmem_wdata(pmem_wdata)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	task automatic check_word(input string name, input lc3b_word actual, input lc3b_word expected);
		if (actual !== expected) begin
			$display("error at %0t ns: %s is %h, expected %h", $time, name, actual, expected);
			$display("Result: FAILED");
			$fatal(1, "value mismatch");
		end
	endtask

	task automatic check_count(input string name, input int actual, input int expected);
		if (actual != expected) begin
			$display("error at %0t ns: %s is %0d, expected %0d", $time, name, actual, expected);
			$display("Result: FAILED");
			$fatal(1, "count mismatch");
		end
	endtask

	function automatic lc3b_word encode(input lc3b_opcode op, input lc3b_reg a,
			input lc3b_reg b, input logic [5:0] low);
		return {op, a, b, low};
	endfunction

	function automatic lc3b_word branch(input lc3b_nzp nzp, input logic [8:0] offset);
		return {op_br, nzp, offset};
	endfunction

	function automatic logic [5:0] imm5(input int value);
		return {1'b1, value[4:0]};
	endfunction

	function automatic logic [5:0] reg_field(input lc3b_reg r);
		return {3'b000, r};
	endfunction

	// ISA model that fills the expected store list and returns its length
	function automatic int run_model();
		lc3b_word r [`MP3_NUM_REGS];
		lc3b_word m [256];
		lc3b_word pc;
		lc3b_word ir;
		lc3b_word a;
		lc3b_word b;
		lc3b_word ea;
		lc3b_word v;
		lc3b_nzp cc;
		logic done;
		m = image;
		foreach (r[i]) r[i] = '0;
		cc = 3'b010;
		pc = `MP3_RESET_PC;
		done = 1'b0;
		exp_addr.delete();
		exp_data.delete();
		for (int steps = 0; steps < 2000 && !done; steps++) begin
			ir = m[pc[8:1]];
			pc = pc + 16'd2;
			a = r[ir[8:6]];
			b = ir[5] ? {{11{ir[4]}}, ir[4:0]} : r[ir[2:0]];
			ea = a + {{9{ir[5]}}, ir[5:0], 1'b0};
			v = '0;
			case (ir[15:12])
				op_add: v = a + b;
				op_and: v = a & b;
				op_not: v = ~a;
				op_ldr: v = m[ea[8:1]];
				op_str: begin
					m[ea[8:1]] = r[ir[11:9]];
					exp_addr.push_back(ea);
					exp_data.push_back(r[ir[11:9]]);
				end
				op_br: begin
					if ((ir[11:9] & cc) != 3'b000) begin
						if (ir[8:0] == 9'h1ff) begin
							done = 1'b1;
							halt_pc = pc - 16'd2;
						end
						pc = pc + {{6{ir[8]}}, ir[8:0], 1'b0};
					end
				end
				default: ;
			endcase
			if (ir[15:12] inside {op_add, op_and, op_not, op_ldr}) begin
				r[ir[11:9]] = v;
				cc = v[15] ? 3'b100 : ((v == '0) ? 3'b010 : 3'b001);
			end
		end
		return exp_addr.size();
	endfunction

	// answers each request after 1 to 4 cycles
	initial begin : memory_model
		int wait_cnt;
		logic next_resp;
		lc3b_word next_rdata;
		pmem_resp = 1'b0;
		pmem_rdata = '0;
		wait_cnt = 0;
		next_rdata = '0;
		forever begin
			@(negedge clk);
			next_resp = 1'b0;
			if (reset) begin
				wait_cnt = 0;
			end else if ((pmem_read || pmem_write) && !pmem_resp) begin
				if (wait_cnt == 0) begin
					wait_cnt = 1 + $unsigned($random(seed)) % 4;
				end
				wait_cnt = wait_cnt - 1;
				if (wait_cnt == 0) begin
					next_resp = 1'b1;
					next_rdata = mem[pmem_address[8:1]];
					if (pmem_write) begin
						mem[pmem_address[8:1]] = pmem_wdata;
					end
				end
			end
			@(posedge clk);
			#1;
			pmem_resp = next_resp;
			pmem_rdata = next_rdata;
		end
	end

	// compares every store and counts fetches of the halt word
	initial begin : compare
		forever begin
			@(negedge clk);
			if (!reset && pmem_resp && pmem_write) begin
				if (store_idx >= exp_addr.size()) begin
					$display("store to %h at %0t ns is not on the model's path", pmem_address, $time);
					$display("Result: FAILED");
					$fatal(1, "extra store");
				end else begin
					check_word("pmem_address", pmem_address, exp_addr[store_idx]);
					check_word("pmem_wdata", pmem_wdata, exp_data[store_idx]);
					store_idx++;
				end
			end else if (!reset && pmem_resp && pmem_read && pmem_address == halt_pc) begin
				halt_hits++;
			end
		end
	end

	initial begin : watchdog
		#(NUM_PROGRAMS * 400 * CLK_PERIOD);
		$display("timeout: the pipeline did not finish all programs in time");
		$display("Result: FAILED");
		$fatal(1, "timeout");
	end

	task automatic emit(input lc3b_word w);
		image[emit_ptr] = w;
		emit_ptr++;
	endtask

	// fill the image, clear r0-r6 and point r7 at the data area 0x0100
	task automatic start_program();
		for (int i = 0; i < 256; i++) begin
			image[i] = {i[7:0], ~i[7:0]};
		end
		emit_ptr = 0;
		for (int i = 0; i < 8; i++) begin
			emit(encode(op_and, lc3b_reg'(i), lc3b_reg'(i), imm5(0)));
		end
		emit(encode(op_add, 3'd7, 3'd7, imm5(8)));
		repeat (5) emit(encode(op_add, 3'd7, 3'd7, reg_field(3'd7)));
	endtask

	task automatic run_program();
		int expected_stores;
		emit(branch(3'b111, 9'h1ff));
		@(posedge clk);
		#1;
		reset = 1'b1;
		repeat (10) @(posedge clk);
		#1;
		expected_stores = run_model();
		mem = image;
		store_idx = 0;
		halt_hits = 0;
		reset = 1'b0;
		// third halt fetch means the self loop closed twice
		wait (halt_hits >= 3);
		check_count("store count", store_idx, expected_stores);
	endtask

	task automatic build_alu();
		start_program();
		emit(encode(op_add, 3'd1, 3'd0, imm5(7)));
		emit(encode(op_add, 3'd2, 3'd0, imm5(-3)));
		emit(encode(op_add, 3'd3, 3'd1, reg_field(3'd2)));
		emit(encode(op_add, 3'd4, 3'd2, imm5(-16)));
		emit(encode(op_and, 3'd5, 3'd1, reg_field(3'd2)));
		emit(encode(op_and, 3'd6, 3'd2, imm5(12)));
		emit(encode(op_not, 3'd1, 3'd2, 6'h3f));
		emit(encode(op_str, 3'd3, 3'd7, 6'd0));
		emit(encode(op_str, 3'd4, 3'd7, 6'd1));
		emit(encode(op_str, 3'd5, 3'd7, 6'd2));
		emit(encode(op_str, 3'd6, 3'd7, 6'd3));
		emit(encode(op_str, 3'd1, 3'd7, 6'd4));
		emit(encode(op_not, 3'd2, 3'd6, 6'h3f));
		emit(encode(op_and, 3'd3, 3'd3, reg_field(3'd0)));
		emit(encode(op_str, 3'd2, 3'd7, 6'd5));
		emit(encode(op_str, 3'd3, 3'd7, 6'd6));
		run_program();
	endtask

	// each instruction reads the one before it
	task automatic build_chain();
		start_program();
		emit(encode(op_add, 3'd1, 3'd0, imm5(5)));
		emit(encode(op_add, 3'd1, 3'd1, reg_field(3'd1)));
		emit(encode(op_add, 3'd2, 3'd1, imm5(-1)));
		emit(encode(op_and, 3'd3, 3'd2, reg_field(3'd1)));
		emit(encode(op_not, 3'd4, 3'd3, 6'h3f));
		emit(encode(op_add, 3'd5, 3'd4, reg_field(3'd2)));
		emit(encode(op_str, 3'd5, 3'd7, 6'd0));
		emit(encode(op_add, 3'd5, 3'd5, imm5(1)));
		emit(encode(op_str, 3'd5, 3'd7, 6'd1));
		emit(encode(op_ldr, 3'd6, 3'd7, 6'd1));
		emit(encode(op_add, 3'd6, 3'd6, reg_field(3'd6)));
		emit(encode(op_str, 3'd6, 3'd7, 6'd2));
		run_program();
	endtask

	task automatic build_loads();
		start_program();
		image[144] = 16'h1234;
		image[145] = 16'h8001;
		image[146] = 16'h00ff;
		emit(encode(op_ldr, 3'd1, 3'd7, 6'd16));
		emit(encode(op_ldr, 3'd2, 3'd7, 6'd17));
		emit(encode(op_add, 3'd3, 3'd1, reg_field(3'd2)));
		emit(encode(op_str, 3'd3, 3'd7, 6'd0));
		emit(encode(op_ldr, 3'd4, 3'd7, 6'd18));
		emit(encode(op_not, 3'd4, 3'd4, 6'h3f));
		emit(encode(op_str, 3'd4, 3'd7, 6'd1));
		emit(encode(op_ldr, 3'd5, 3'd7, 6'd31));
		emit(encode(op_str, 3'd5, 3'd7, 6'd2));
		emit(encode(op_str, 3'd1, 3'd7, 6'd3));
		run_program();
	endtask

	// every nzp mask against n, z and p where a taken branch skips its store
	task automatic build_branches();
		int values [3];
		int slot;
		int nzp;
		values = '{-2, 0, 3};
		start_program();
		slot = 0;
		foreach (values[v]) begin
			emit(encode(op_add, 3'd1, 3'd0, imm5(values[v])));
			for (nzp = 0; nzp < 8; nzp++) begin
				emit(branch(lc3b_nzp'(nzp), 9'd1));
				emit(encode(op_str, 3'd1, 3'd7, 6'(slot)));
				slot++;
			end
		end
		run_program();
	endtask

	// r7 stays the base pointer and branches only go forward
	task automatic build_random();
		lc3b_reg d;
		lc3b_reg a;
		logic [5:0] low;
		int k;
		start_program();
		for (int i = 0; i < 20; i++) begin
			d = lc3b_reg'($unsigned($random(seed)) % 7);
			a = lc3b_reg'($unsigned($random(seed)) % 7);
			low = 6'($random(seed));
			k = $unsigned($random(seed)) % 3;
			if (k > 19 - i) begin
				k = 19 - i;
			end
			case ($unsigned($random(seed)) % 6)
				0: emit(encode(op_add, d, a, low[5] ? low : reg_field(low[2:0])));
				1: emit(encode(op_and, d, a, low[5] ? low : reg_field(low[2:0])));
				2: emit(encode(op_not, d, a, 6'h3f));
				3: emit(encode(op_ldr, d, 3'd7, {1'b0, low[4:0]}));
				4: emit(encode(op_str, d, 3'd7, {1'b0, low[4:0]}));
				default: emit(branch(low[2:0], 9'(k)));
			endcase
		end
		run_program();
	endtask

	initial begin : main
		reset = 1'b1;
		halt_pc = '1;
		store_idx = 0;
		halt_hits = 0;
		build_alu();
		build_chain();
		build_loads();
		build_branches();
		build_random();
		$display("Result: PASSED");
		$finish;
	end

endmodule

`default_nettype wire

//--- sim.f
+incdir+.
lc3b_types.sv
mem_port_if.sv
arbiter.sv
fetch.sv
decode.sv
execute.sv
mem.sv
mp3.sv
mp3_props.sv
mp3_tb.sv

//--- Bender.yml
package:
  name: mp3

export_include_dirs:
  - .

sources:
  - lc3b_types.sv
  - mem_port_if.sv
  - arbiter.sv
  - fetch.sv
  - decode.sv
  - execute.sv
  - mem.sv
  - mp3.sv
  - target: test
    files:
      - mp3_props.sv
      - mp3_tb.sv
